/* verilog/geom_types_pkg.sv */
// Geometry data types for the binning engine
// Pixel, depth, area and tile widths plus screen and tile geometry

package geom_types_pkg;

    typedef logic        [15:0] coord_t;
    typedef logic signed [15:0] depth_t;
    typedef logic signed [33:0] area_t;

    typedef logic [1:0]  tile_coord_t;
    // Row * 4 + column
    typedef logic [3:0]  tile_idx_t;
    typedef logic [15:0] tile_count_t;

    typedef logic [3:0]  tri_cnt_t;
    typedef logic [4:0]  vert_idx_t;
    typedef logic [31:0] perf_t;

    // ========================================================================
    // Screen geometry, 128x128 pixels in 32-pixel tiles
    // ========================================================================
    localparam int TILE_SHIFT     = 5;
    localparam int TILES_X        = 4;
    localparam int TILES_Y        = 4;
    localparam int NUM_TILES      = TILES_X * TILES_Y;
    localparam int MAX_TILE_COORD = 3;

    // Vertex store capacity
    localparam int MAX_TRIS  = 8;
    localparam int MAX_VERTS = 3 * MAX_TRIS;

endpackage

/* verilog/geom_regs_pkg.sv */
// Host register map for the Wishbone slave port
// Bus widths and word addresses of control, status, tiles and vertices

package geom_regs_pkg;

    typedef logic [7:0]  wb_addr_t;
    typedef logic [31:0] wb_data_t;

    // ========================================================================
    // Word addresses
    // ========================================================================
    // Bits 3..0 carry the triangle count, a write starts the run
    localparam wb_addr_t REG_CTRL        = 8'h00;
    // Bit 0 busy
    localparam wb_addr_t REG_STATUS      = 8'h01;
    localparam wb_addr_t REG_PERF_PRIMS  = 8'h02;
    localparam wb_addr_t REG_PERF_CULLED = 8'h03;

    // Tile i at TILE_BASE + i
    localparam wb_addr_t TILE_BASE = 8'h10;

    // Vertex v uses two words, {y, x} at VERT_BASE + 2v and z at VERT_BASE + 2v + 1
    localparam wb_addr_t VERT_BASE = 8'h40;

endpackage

/* verilog/tile_bin_store.sv */
// Per-tile primitive counters
// Clear and increment at the sweep position, host read port

`timescale 1ns/1ps

module tile_bin_store (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        clear,
    input  logic                        incr,
    input  geom_types_pkg::tile_coord_t tile_x,
    input  geom_types_pkg::tile_coord_t tile_y,
    input  geom_types_pkg::tile_idx_t   rd_tile,
    output geom_types_pkg::tile_count_t rd_count
);

    geom_types_pkg::tile_count_t counts [geom_types_pkg::NUM_TILES];
    geom_types_pkg::tile_idx_t   idx;

    assign idx = {tile_y, tile_x};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < geom_types_pkg::NUM_TILES; i++) begin
                counts[i] <= '0;
            end
        end else if (clear) begin
            counts[idx] <= '0;
        end else if (incr) begin
            counts[idx] <= counts[idx] + 16'd1;
        end
    end

    assign rd_count = counts[rd_tile];

endmodule

/* verilog/tile_sweep_counter.sv */
// Tile walker over the whole grid or over one bounding box
// Row by row, one tile per step, last flags the final tile

`timescale 1ns/1ps

module tile_sweep_counter (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        sweep_start,
    input  logic                        sweep_full,
    input  logic                        step,
    input  geom_types_pkg::tile_coord_t bb_min_x,
    input  geom_types_pkg::tile_coord_t bb_max_x,
    input  geom_types_pkg::tile_coord_t bb_min_y,
    input  geom_types_pkg::tile_coord_t bb_max_y,
    output geom_types_pkg::tile_coord_t tile_x,
    output geom_types_pkg::tile_coord_t tile_y,
    output logic                        last
);

    // Walk limits captured at start
    geom_types_pkg::tile_coord_t lo_x;
    geom_types_pkg::tile_coord_t hi_x;
    geom_types_pkg::tile_coord_t hi_y;

    assign last = (tile_x == hi_x) && (tile_y == hi_y);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tile_x <= '0;
            tile_y <= '0;
            lo_x   <= '0;
            hi_x   <= '0;
            hi_y   <= '0;
        end else if (sweep_start) begin
            tile_x <= sweep_full ? '0 : bb_min_x;
            tile_y <= sweep_full ? '0 : bb_min_y;
            lo_x   <= sweep_full ? '0 : bb_min_x;
            hi_x   <= sweep_full ? 2'(geom_types_pkg::TILES_X - 1) : bb_max_x;
            hi_y   <= sweep_full ? 2'(geom_types_pkg::TILES_Y - 1) : bb_max_y;
        end else if (step) begin
            if (tile_x == hi_x) begin
                tile_x <= lo_x;
                tile_y <= tile_y + 2'd1;
            end else begin
                tile_x <= tile_x + 2'd1;
            end
        end
    end

endmodule

/* verilog/tri_setup.sv */
// Triangle setup
// Vertex registers, signed-area and behind-viewer culling, tile bounding box

`timescale 1ns/1ps

module tri_setup (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [2:0]                  load_vert,
    input  geom_types_pkg::coord_t      vx,
    input  geom_types_pkg::coord_t      vy,
    input  geom_types_pkg::depth_t      vz,
    output logic                        visible,
    output geom_types_pkg::tile_coord_t bb_min_x,
    output geom_types_pkg::tile_coord_t bb_max_x,
    output geom_types_pkg::tile_coord_t bb_min_y,
    output geom_types_pkg::tile_coord_t bb_max_y
);

    geom_types_pkg::coord_t px [3];
    geom_types_pkg::coord_t py [3];
    geom_types_pkg::depth_t pz [3];

    logic signed [16:0]     e1x, e1y, e2x, e2y;
    geom_types_pkg::area_t  area;
    logic                   behind;

    function automatic geom_types_pkg::coord_t min3(input geom_types_pkg::coord_t a,
                                                    input geom_types_pkg::coord_t b,
                                                    input geom_types_pkg::coord_t c);
        geom_types_pkg::coord_t m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic geom_types_pkg::coord_t max3(input geom_types_pkg::coord_t a,
                                                    input geom_types_pkg::coord_t b,
                                                    input geom_types_pkg::coord_t c);
        geom_types_pkg::coord_t m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    // Pixel to tile, clamped to the right and bottom edge of the grid
    function automatic geom_types_pkg::tile_coord_t to_tile(input geom_types_pkg::coord_t c);
        geom_types_pkg::coord_t t;
        t = c >> geom_types_pkg::TILE_SHIFT;
        if (t > geom_types_pkg::MAX_TILE_COORD) begin
            return geom_types_pkg::tile_coord_t'(geom_types_pkg::MAX_TILE_COORD);
        end
        return geom_types_pkg::tile_coord_t'(t);
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < 3; k++) begin
                px[k] <= '0;
                py[k] <= '0;
                pz[k] <= '0;
            end
        end else begin
            for (int k = 0; k < 3; k++) begin
                if (load_vert[k]) begin
                    px[k] <= vx;
                    py[k] <= vy;
                    pz[k] <= vz;
                end
            end
        end
    end

    // ========================================================================
    // Culling, valid the cycle after the third load
    // ========================================================================
    always_comb begin
        e1x  = $signed({1'b0, px[1]}) - $signed({1'b0, px[0]});
        e1y  = $signed({1'b0, py[1]}) - $signed({1'b0, py[0]});
        e2x  = $signed({1'b0, px[2]}) - $signed({1'b0, px[0]});
        e2y  = $signed({1'b0, py[2]}) - $signed({1'b0, py[0]});
        area = e1x * e2y - e2x * e1y;
    end

    assign behind  = (pz[0] < 0) && (pz[1] < 0) && (pz[2] < 0);
    assign visible = (area > 0) && !behind;

    assign bb_min_x = to_tile(min3(px[0], px[1], px[2]));
    assign bb_max_x = to_tile(max3(px[0], px[1], px[2]));
    assign bb_min_y = to_tile(min3(py[0], py[1], py[2]));
    assign bb_max_y = to_tile(max3(py[0], py[1], py[2]));

endmodule

/* verilog/geom_ctrl_fsm.sv */
// Sequencing FSM for clear, assembly, culling and binning
// Triangle and vertex counting plus processed and culled tallies

`timescale 1ns/1ps

module geom_ctrl_fsm (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  geom_types_pkg::tri_cnt_t  tri_count,
    input  logic                      visible,
    input  logic                      last,
    output logic                      busy,
    output logic                      done,
    output geom_types_pkg::vert_idx_t rd_vert,
    output logic [2:0]                load_vert,
    output logic                      sweep_start,
    output logic                      sweep_full,
    output logic                      step,
    output logic                      clear,
    output logic                      incr,
    output geom_types_pkg::perf_t     perf_prims,
    output geom_types_pkg::perf_t     perf_culled
);

    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        LOAD,
        CULL,
        BIN,
        DONE
    } ctrl_state_t;

    ctrl_state_t              state;
    ctrl_state_t              next_state;
    geom_types_pkg::tri_cnt_t tri_total;
    geom_types_pkg::tri_cnt_t tri_done;
    logic [1:0]               vert_slot;
    logic                     last_tri;
    logic                     tri_end;

    assign last_tri = (tri_done == tri_total - 4'd1);
    // Triangle finished, either culled or fully binned
    assign tri_end  = (state == CULL && !visible) || (state == BIN && last);

    always_comb begin
        next_state = state;
        case (state)
            IDLE:  if (start) next_state = CLEAR;
            CLEAR: if (last) next_state = (tri_total == '0) ? DONE : LOAD;
            LOAD:  if (vert_slot == 2'd2) next_state = CULL;
            CULL: begin
                if (visible) next_state = BIN;
                else         next_state = last_tri ? DONE : LOAD;
            end
            BIN:   if (last) next_state = last_tri ? DONE : LOAD;
            DONE:  next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    // Whole grid walk for the clear, box walk for each visible triangle
    assign sweep_start = (state == IDLE && start) || (state == CULL && visible);
    assign sweep_full  = (state == IDLE);
    assign step        = (state == CLEAR) || (state == BIN);
    assign clear       = (state == CLEAR);
    assign incr        = (state == BIN);
    assign busy        = (state != IDLE);
    assign done        = (state == DONE);
    assign load_vert   = (state == LOAD) ? (3'b001 << vert_slot) : 3'b000;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= IDLE;
            tri_total   <= '0;
            tri_done    <= '0;
            vert_slot   <= '0;
            rd_vert     <= '0;
            perf_prims  <= '0;
            perf_culled <= '0;
        end else begin
            state <= next_state;
            if (state == IDLE && start) begin
                tri_total <= tri_count;
                tri_done  <= '0;
                vert_slot <= '0;
                rd_vert   <= '0;
            end
            if (state == LOAD) begin
                rd_vert   <= rd_vert + 5'd1;
                vert_slot <= (vert_slot == 2'd2) ? 2'd0 : vert_slot + 2'd1;
            end
            if (tri_end) begin
                tri_done <= tri_done + 4'd1;
            end
            // Tallies run across starts and clear only on reset
            if (state == CULL) begin
                perf_prims <= perf_prims + 32'd1;
                if (!visible) begin
                    perf_culled <= perf_culled + 32'd1;
                end
            end
        end
    end

endmodule

/* verilog/geom_wb_regs.sv */
// Wishbone classic slave for the binning engine
// Vertex store, start command, registered ack and read data mux

`timescale 1ns/1ps

module geom_wb_regs (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  geom_regs_pkg::wb_addr_t     wb_adr,
    input  geom_regs_pkg::wb_data_t     wb_dat_w,
    output geom_regs_pkg::wb_data_t     wb_dat_r,
    output logic                        wb_ack,
    input  logic                        busy,
    input  geom_types_pkg::perf_t       perf_prims,
    input  geom_types_pkg::perf_t       perf_culled,
    input  geom_types_pkg::vert_idx_t   rd_vert,
    input  geom_types_pkg::tile_count_t rd_count,
    output logic                        start,
    output geom_types_pkg::tri_cnt_t    tri_count,
    output geom_types_pkg::coord_t      vx,
    output geom_types_pkg::coord_t      vy,
    output geom_types_pkg::depth_t      vz,
    output geom_types_pkg::tile_idx_t   rd_tile
);

    geom_types_pkg::coord_t    vert_x [geom_types_pkg::MAX_VERTS];
    geom_types_pkg::coord_t    vert_y [geom_types_pkg::MAX_VERTS];
    geom_types_pkg::depth_t    vert_z [geom_types_pkg::MAX_VERTS];

    logic                      req;
    logic                      wr;
    logic                      in_vert;
    logic                      in_tile;
    geom_regs_pkg::wb_addr_t   vert_off;
    geom_types_pkg::vert_idx_t wr_vert;
    geom_types_pkg::tri_cnt_t  cmd_count;

    // First cycle of a bus cycle, ack not yet given
    assign req = wb_cyc & wb_stb & ~wb_ack;
    assign wr  = req & wb_we;

    assign in_vert  = (wb_adr >= geom_regs_pkg::VERT_BASE) &&
                      (wb_adr < geom_regs_pkg::VERT_BASE + 2 * geom_types_pkg::MAX_VERTS);
    assign in_tile  = (wb_adr >= geom_regs_pkg::TILE_BASE) &&
                      (wb_adr < geom_regs_pkg::TILE_BASE + geom_types_pkg::NUM_TILES);
    assign vert_off = wb_adr - geom_regs_pkg::VERT_BASE;
    assign wr_vert  = geom_types_pkg::vert_idx_t'(vert_off >> 1);
    assign rd_tile  = geom_types_pkg::tile_idx_t'(wb_adr - geom_regs_pkg::TILE_BASE);

    // Larger counts would run past the store
    assign cmd_count = (wb_dat_w[3:0] > geom_types_pkg::MAX_TRIS) ?
                       geom_types_pkg::tri_cnt_t'(geom_types_pkg::MAX_TRIS) : wb_dat_w[3:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack    <= 1'b0;
            start     <= 1'b0;
            tri_count <= '0;
        end else begin
            wb_ack <= req;
            start  <= 1'b0;
            if (wr && wb_adr == geom_regs_pkg::REG_CTRL && !busy && !start) begin
                start     <= 1'b1;
                tri_count <= cmd_count;
            end
        end
    end

    // ========================================================================
    // Vertex store, frozen while the engine runs
    // ========================================================================
    always_ff @(posedge clk) begin
        if (wr && in_vert && !busy) begin
            if (!vert_off[0]) begin
                vert_x[wr_vert] <= wb_dat_w[15:0];
                vert_y[wr_vert] <= wb_dat_w[31:16];
            end else begin
                vert_z[wr_vert] <= geom_types_pkg::depth_t'(wb_dat_w[15:0]);
            end
        end
    end

    // Engine read port, index runs one past the end after the last triangle
    always_comb begin
        vx = '0;
        vy = '0;
        vz = '0;
        if (rd_vert < geom_types_pkg::MAX_VERTS) begin
            vx = vert_x[rd_vert];
            vy = vert_y[rd_vert];
            vz = vert_z[rd_vert];
        end
    end

    // Host read mux
    always_comb begin
        wb_dat_r = '0;
        if (in_tile) begin
            wb_dat_r = {16'h0000, rd_count};
        end else if (in_vert) begin
            if (!vert_off[0]) begin
                wb_dat_r = {vert_y[wr_vert], vert_x[wr_vert]};
            end else begin
                wb_dat_r = {16'h0000, vert_z[wr_vert]};
            end
        end else begin
            case (wb_adr)
                geom_regs_pkg::REG_CTRL:        wb_dat_r = {28'h0, tri_count};
                geom_regs_pkg::REG_STATUS:      wb_dat_r = {31'h0, busy};
                geom_regs_pkg::REG_PERF_PRIMS:  wb_dat_r = perf_prims;
                geom_regs_pkg::REG_PERF_CULLED: wb_dat_r = perf_culled;
                default:                        wb_dat_r = '0;
            endcase
        end
    end

endmodule

/* verilog/geom_top.sv */
// Top level of the triangle binning engine
// Connects the Wishbone slave, the controller and the setup and binning datapath

`timescale 1ns/1ps

module geom_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  geom_regs_pkg::wb_addr_t wb_adr,
    input  geom_regs_pkg::wb_data_t wb_dat_w,
    output geom_regs_pkg::wb_data_t wb_dat_r,
    output logic                   wb_ack,
    output logic                   done
);

    // Host side
    logic                         start;
    geom_types_pkg::tri_cnt_t     tri_count;
    logic                         busy;
    geom_types_pkg::perf_t        perf_prims;
    geom_types_pkg::perf_t        perf_culled;

    // Vertex fetch into setup
    geom_types_pkg::vert_idx_t    rd_vert;
    geom_types_pkg::coord_t       vx;
    geom_types_pkg::coord_t       vy;
    geom_types_pkg::depth_t       vz;
    logic [2:0]                   load_vert;

    // Setup results
    logic                         visible;
    geom_types_pkg::tile_coord_t  bb_min_x;
    geom_types_pkg::tile_coord_t  bb_max_x;
    geom_types_pkg::tile_coord_t  bb_min_y;
    geom_types_pkg::tile_coord_t  bb_max_y;

    // Sweep and bin store
    logic                         sweep_start;
    logic                         sweep_full;
    logic                         step;
    logic                         last;
    geom_types_pkg::tile_coord_t  tile_x;
    geom_types_pkg::tile_coord_t  tile_y;
    logic                         clear;
    logic                         incr;
    geom_types_pkg::tile_idx_t    rd_tile;
    geom_types_pkg::tile_count_t  rd_count;

    geom_wb_regs u_regs (
        .clk, .rst_n,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .busy, .perf_prims, .perf_culled, .rd_vert, .rd_count,
        .start, .tri_count, .vx, .vy, .vz, .rd_tile
    );

    geom_ctrl_fsm u_ctrl (
        .clk, .rst_n, .start, .tri_count, .visible, .last,
        .busy, .done, .rd_vert, .load_vert, .sweep_start, .sweep_full, .step,
        .clear, .incr, .perf_prims, .perf_culled
    );

    tri_setup u_setup (
        .clk, .rst_n, .load_vert, .vx, .vy, .vz,
        .visible, .bb_min_x, .bb_max_x, .bb_min_y, .bb_max_y
    );

    tile_sweep_counter u_sweep (
        .clk, .rst_n, .sweep_start, .sweep_full, .step,
        .bb_min_x, .bb_max_x, .bb_min_y, .bb_max_y,
        .tile_x, .tile_y, .last
    );

    tile_bin_store u_bins (
        .clk, .rst_n, .clear, .incr, .tile_x, .tile_y, .rd_tile, .rd_count
    );

endmodule

/* verif/geom_props.sv */
// Bound checks on the Wishbone handshake, the done pulse and tile binning
// Each property also raises a flag that the testbench watches

`timescale 1ns/1ps

module geom_props (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        wb_cyc,
    input logic                        wb_stb,
    input logic                        wb_ack,
    input logic                        done,
    input logic                        busy,
    input logic                        incr,
    input geom_types_pkg::tile_coord_t tile_x,
    input geom_types_pkg::tile_coord_t tile_y,
    input geom_types_pkg::tile_coord_t bb_min_x,
    input geom_types_pkg::tile_coord_t bb_max_x,
    input geom_types_pkg::tile_coord_t bb_min_y,
    input geom_types_pkg::tile_coord_t bb_max_y
);

    logic ack_src_fail  = 1'b0;
    logic ack_len_fail  = 1'b0;
    logic done_fail     = 1'b0;
    logic busy_end_fail = 1'b0;
    logic incr_fail     = 1'b0;
    logic any_fail;

    assign any_fail = ack_src_fail | ack_len_fail | done_fail | busy_end_fail | incr_fail;

    // ========================================================================
    // Wishbone handshake
    // ========================================================================
    ack_after_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else begin
            ack_src_fail = 1'b1;
            $error("ack without a strobe in the cycle before");
        end

    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
        else begin
            ack_len_fail = 1'b1;
            $error("ack held longer than one cycle");
        end

    // Done marks the falling edge of busy, both ways
    done_at_busy_fall: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> $fell(busy))
        else begin
            done_fail = 1'b1;
            $error("done not followed by busy falling");
        end

    busy_fall_has_done: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> $past(done))
        else begin
            busy_end_fail = 1'b1;
            $error("busy fell without a done pulse");
        end

    // Binning never touches a tile outside the current box
    incr_in_box: assert property (@(posedge clk) disable iff (!rst_n)
        incr |-> (tile_x >= bb_min_x) && (tile_x <= bb_max_x) &&
                 (tile_y >= bb_min_y) && (tile_y <= bb_max_y))
        else begin
            incr_fail = 1'b1;
            $error("tile increment outside the bounding box");
        end

endmodule

/* verif/tb_geom.sv */
// Testbench for the triangle binning engine
// Wishbone bus tasks, reference tile model, directed and random runs, timeout

`timescale 1ns/1ps

module tb_geom;

    // Worst case of 10 runs with 8 triangles over 16 tiles each plus bus traffic
    localparam int RUN_CYCLES     = 1 + 16 + 8 * (3 + 1 + 16);
    localparam int BUS_CYCLES     = 2 * (2 * geom_types_pkg::MAX_VERTS + 1 + 16 + 4);
    localparam int TIMEOUT_CYCLES = 2 * 10 * (RUN_CYCLES + BUS_CYCLES);

    logic                    clk;
    logic                    rst_n;
    logic                    wb_cyc;
    logic                    wb_stb;
    logic                    wb_we;
    geom_regs_pkg::wb_addr_t wb_adr;
    geom_regs_pkg::wb_data_t wb_dat_w;
    geom_regs_pkg::wb_data_t wb_dat_r;
    logic                    wb_ack;
    logic                    done;

    // Reference model of the vertex store, tile grid and tallies
    int     vert_mx [geom_types_pkg::MAX_VERTS];
    int     vert_my [geom_types_pkg::MAX_VERTS];
    int     vert_mz [geom_types_pkg::MAX_VERTS];
    int     exp_tiles [geom_types_pkg::NUM_TILES];
    int     exp_prims;
    int     exp_culled;
    int     exp_latency;
    int     cycles = 0;
    int     done_count = 0;
    int     done_before;
    int     edge_count = 0;
    int     start_edge;
    int     done_edge;
    integer seed;

    geom_top uut (
        .clk, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr,
        .wb_dat_w, .wb_dat_r, .wb_ack, .done
    );

    bind geom_top geom_props props (
        .clk(clk), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack),
        .done(done), .busy(busy), .incr(incr), .tile_x(tile_x), .tile_y(tile_y),
        .bb_min_x(bb_min_x), .bb_max_x(bb_max_x), .bb_min_y(bb_min_y), .bb_max_y(bb_max_y)
    );

    always #50 clk = ~clk;

    // Rising edges counted so the start to done latency can be measured
    always @(posedge clk) begin
        edge_count <= edge_count + 1;
        if (done) begin
            done_count <= done_count + 1;
            done_edge  <= edge_count;
        end
    end

    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    always @(negedge clk) begin
        cycles = cycles + 1;
        if (uut.props.any_fail) begin
            $display("A bound protocol assertion failed at time %0t", $time);
            abort_run();
        end else if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual == expected) else begin
            $display("[ERROR] time %0t: %s expected %0d, actual %0d",
                     $time, name, expected, actual);
            abort_run();
        end
    endtask

    // ========================================================================
    // Wishbone classic host driven on the falling edge
    // ========================================================================
    task automatic wait_ack();
        @(negedge clk);
        while (!wb_ack) begin
            @(negedge clk);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic bus_write(input geom_regs_pkg::wb_addr_t addr,
                             input geom_regs_pkg::wb_data_t data);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = addr;
        wb_dat_w = data;
        wait_ack();
    endtask

    task automatic read_check(input geom_regs_pkg::wb_addr_t addr, input string name,
                              input logic [31:0] expected);
        logic [31:0] data;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = addr;
        @(negedge clk);
        while (!wb_ack) begin
            @(negedge clk);
        end
        data   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        check_value(name, expected, data);
    endtask

    task automatic load_vertex(input int v, input int x, input int y, input int z);
        vert_mx[v] = x;
        vert_my[v] = y;
        vert_mz[v] = z;
        bus_write(geom_regs_pkg::VERT_BASE + 8'(2 * v), {y[15:0], x[15:0]});
        bus_write(geom_regs_pkg::VERT_BASE + 8'(2 * v + 1), {16'h0000, z[15:0]});
    endtask

    function automatic int smallest(input int a, input int b, input int c);
        int m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic int largest(input int a, input int b, input int c);
        int m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    function automatic int tile_of(input int pixel);
        return (pixel / 32 > 3) ? 3 : pixel / 32;
    endfunction

    // Culls on area <= 0 or all z behind and otherwise adds one over the tile box
    task automatic predict_run(input int n);
        int b;
        int area;
        int x_lo;
        int x_hi;
        int y_lo;
        int y_hi;
        for (int i = 0; i < geom_types_pkg::NUM_TILES; i++) begin
            exp_tiles[i] = 0;
        end
        // Grid clear, then 3 loads and a cull per triangle plus one cycle per binned tile
        exp_latency = 1 + geom_types_pkg::NUM_TILES;
        for (int t = 0; t < n; t++) begin
            b = 3 * t;
            area = (vert_mx[b + 1] - vert_mx[b]) * (vert_my[b + 2] - vert_my[b]) -
                   (vert_mx[b + 2] - vert_mx[b]) * (vert_my[b + 1] - vert_my[b]);
            exp_prims++;
            exp_latency += 4;
            if (area <= 0 || (vert_mz[b] < 0 && vert_mz[b + 1] < 0 && vert_mz[b + 2] < 0)) begin
                exp_culled++;
            end else begin
                x_lo = tile_of(smallest(vert_mx[b], vert_mx[b + 1], vert_mx[b + 2]));
                x_hi = tile_of(largest(vert_mx[b], vert_mx[b + 1], vert_mx[b + 2]));
                y_lo = tile_of(smallest(vert_my[b], vert_my[b + 1], vert_my[b + 2]));
                y_hi = tile_of(largest(vert_my[b], vert_my[b + 1], vert_my[b + 2]));
                exp_latency += (x_hi - x_lo + 1) * (y_hi - y_lo + 1);
                for (int ty = y_lo; ty <= y_hi; ty++) begin
                    for (int tx = x_lo; tx <= x_hi; tx++) begin
                        exp_tiles[ty * 4 + tx]++;
                    end
                end
            end
        end
    endtask

    task automatic check_results();
        read_check(geom_regs_pkg::REG_STATUS, "STATUS", 32'd0);
        read_check(geom_regs_pkg::REG_PERF_PRIMS, "PERF_PRIMS", 32'(exp_prims));
        read_check(geom_regs_pkg::REG_PERF_CULLED, "PERF_CULLED", 32'(exp_culled));
        for (int i = 0; i < geom_types_pkg::NUM_TILES; i++) begin
            read_check(geom_regs_pkg::TILE_BASE + 8'(i), $sformatf("TILE[%0d]", i),
                       32'(exp_tiles[i]));
        end
    endtask

    task automatic start_run(input int n);
        predict_run(n);
        done_before = done_count;
        bus_write(geom_regs_pkg::REG_CTRL, 32'(n));
        start_edge = edge_count;
        read_check(geom_regs_pkg::REG_STATUS, "STATUS", 32'd1);
    endtask

    task automatic finish_run();
        while (done_count == done_before) begin
            @(negedge clk);
        end
        check_value("start to done cycles", 32'(exp_latency), 32'(done_edge - start_edge));
        check_results();
    endtask

    initial begin
        seed     = 45;
        clk      = 1'b0;
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        // Quiet after reset
        check_value("done", 32'd0, 32'(done));
        check_value("wb_ack", 32'd0, 32'(wb_ack));
        check_results();

        // One front-facing triangle
        load_vertex(0, 10, 10, 5);
        load_vertex(1, 70, 10, 5);
        load_vertex(2, 10, 70, 5);
        start_run(1);
        finish_run();

        // Clockwise, degenerate, all behind, then a visible one with mixed z
        load_vertex(0, 10, 10, 5);
        load_vertex(1, 10, 70, 5);
        load_vertex(2, 70, 10, 5);
        load_vertex(3, 0, 0, 1);
        load_vertex(4, 50, 50, 1);
        load_vertex(5, 100, 100, 1);
        load_vertex(6, 20, 20, -3);
        load_vertex(7, 120, 20, -1);
        load_vertex(8, 20, 120, -7);
        load_vertex(9, 40, 40, -2);
        load_vertex(10, 127, 60, 3);
        load_vertex(11, 60, 127, -2);
        start_run(4);
        finish_run();

        // Zero count only clears the grid
        start_run(0);
        finish_run();

        // Random runs where each start clears the previous bins
        for (int r = 0; r < 3; r++) begin
            for (int v = 0; v < geom_types_pkg::MAX_VERTS; v++) begin
                load_vertex(v, $unsigned($random(seed)) % 128,
                            $unsigned($random(seed)) % 128, $random(seed) % 64);
            end
            start_run(8);
            finish_run();
        end

        // Two visible triangles up front so that lost writes would show as culls
        load_vertex(0, 0, 0, 1);
        load_vertex(1, 40, 0, 1);
        load_vertex(2, 0, 40, 1);
        load_vertex(3, 90, 90, 4);
        load_vertex(4, 127, 90, 4);
        load_vertex(5, 90, 127, 4);

        // Writes during a run would collapse the first two triangles
        start_run(8);
        for (int v = 0; v < 6; v++) begin
            bus_write(geom_regs_pkg::VERT_BASE + 8'(2 * v), {16'd5, 16'd5});
        end
        finish_run();
        start_run(8);
        finish_run();

        $display(">>> PASS");
        $finish;
    end

endmodule

/* files.f */
verilog/geom_types_pkg.sv
verilog/geom_regs_pkg.sv
verilog/tile_bin_store.sv
verilog/tile_sweep_counter.sv
verilog/tri_setup.sv
verilog/geom_ctrl_fsm.sv
verilog/geom_wb_regs.sv
verilog/geom_top.sv
verif/geom_props.sv
verif/tb_geom.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --assert --timing -Wno-fatal
TOP      = tb_geom
FILELIST = files.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^>>> PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
